//--- common/icache_consts.svh
/* Instruction cache constants
   Word address split into tag, set and offset, and the instruction width */

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Tag compared against both ways
`define ICACHE_TAG_BITS 14
// 16 sets
`define ICACHE_SET_BITS 4
// 4-word blocks
`define ICACHE_OFFSET_BITS 2

`define ICACHE_WORD_BITS 32

// Full word address, tag in the upper bits
`define ICACHE_ADDR_BITS (`ICACHE_TAG_BITS + `ICACHE_SET_BITS + `ICACHE_OFFSET_BITS)

`endif

//--- common/icachePkg.sv
/* Instruction cache types
   Address field vectors and the structs passed between the cache stages */

`include "icache_consts.svh"

package icachePkg;

  typedef logic [`ICACHE_TAG_BITS-1:0]    tagT;
  typedef logic [`ICACHE_SET_BITS-1:0]    setT;
  typedef logic [`ICACHE_OFFSET_BITS-1:0] offsetT;
  typedef logic [`ICACHE_WORD_BITS-1:0]   wordT;
  typedef logic [`ICACHE_ADDR_BITS-1:0]   wordAddrT;

  // Registered fetch request, address already split
  typedef struct packed {
    logic   valid;
    tagT    tag;
    setT    set;
    offsetT offset;
  } lookupT;

  // Tag state of both ways for the looked-up set
  typedef struct packed {
    logic way1Valid;
    logic way2Valid;
    tagT  way1Tag;
    tagT  way2Tag;
    logic lru;        // Set when way 1 is least recent
  } wayTagsT;

  // Write command from the miss controller
  typedef struct packed {
    logic   way1We;
    logic   way2We;
    offsetT wayOffset;
    logic   markValid;
    logic   wayRead;  // Set to read way 1
  } fillT;

endpackage

//--- icache/icacheLookup.sv
/* Instruction cache lookup stage
   Registers the fetch request and splits the word address into tag, set and offset */

`timescale 1ns/1ps

`include "icache_consts.svh"

module icacheLookup (
  input  logic                clk,
  input  logic                reset,
  input  logic                fetchValid,
  input  icachePkg::wordAddrT fetchAddr,
  input  logic                stall,
  output icachePkg::lookupT   lookup
);

  import icachePkg::*;

  logic   validQ;
  tagT    tagQ;
  setT    setQ;
  offsetT offsetQ;

  tagT    fetchTag;
  setT    fetchSet;
  offsetT fetchOffset;

  // Tag on top, then set index, then word within the block
  assign fetchTag    = fetchAddr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  assign fetchSet    = fetchAddr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
  assign fetchOffset = fetchAddr[`ICACHE_OFFSET_BITS-1:0];

  // Request valid, held during a fill so the same fetch is looked up again
  always_ff @(posedge clk) begin
    if (reset) begin
      validQ <= 1'b0;
    end else if (!stall) begin
      validQ <= fetchValid;
    end
  end

  // Address fields
  always_ff @(posedge clk) begin
    if (!stall) begin
      tagQ    <= fetchTag;
      setQ    <= fetchSet;
      offsetQ <= fetchOffset;
    end
  end

  assign lookup.valid  = validQ;
  assign lookup.tag    = tagQ;
  assign lookup.set    = setQ;
  assign lookup.offset = offsetQ;

endmodule

//--- icache/icacheWays.sv
/* Instruction cache way store
   Tag, valid, LRU and data arrays of both ways, read at the looked-up set.
   Takes fill writes from the miss controller and returns the selected word */

`timescale 1ns/1ps

`include "icache_consts.svh"

module icacheWays (
  input  logic               clk,
  input  logic               reset,
  input  icachePkg::lookupT  lookup,
  input  icachePkg::fillT    fill,
  input  icachePkg::wordT    busData,
  input  logic               cacheEnable,
  output icachePkg::wayTagsT tags,
  output icachePkg::wordT    instr
);

  import icachePkg::*;

  localparam int Sets  = 1 << `ICACHE_SET_BITS;
  localparam int Words = 1 << `ICACHE_OFFSET_BITS;

  // Per-set state bits
  logic [Sets-1:0] valid1;
  logic [Sets-1:0] valid2;
  logic [Sets-1:0] lru;

  tagT  tag1 [Sets];
  tagT  tag2 [Sets];

  // One 4-word line per set and way
  wordT data1 [Sets][Words];
  wordT data2 [Sets][Words];

  logic readWay1Hit;
  logic readWay2Hit;
  logic readHit;

  // Combinational read of the looked-up set
  assign tags.way1Valid = valid1[lookup.set];
  assign tags.way2Valid = valid2[lookup.set];
  assign tags.way1Tag   = tag1[lookup.set];
  assign tags.way2Tag   = tag2[lookup.set];
  assign tags.lru       = lru[lookup.set];

  assign instr = fill.wayRead ? data1[lookup.set][lookup.offset]
                              : data2[lookup.set][lookup.offset];

  // Hit in the way being read, only counts for LRU when caching
  assign readWay1Hit = tags.way1Valid & (tags.way1Tag == lookup.tag);
  assign readWay2Hit = tags.way2Valid & (tags.way2Tag == lookup.tag);
  assign readHit     = lookup.valid & cacheEnable &
                       (fill.wayRead ? readWay1Hit : readWay2Hit);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid1 <= '0;
      valid2 <= '0;
      lru    <= '0;
    end else begin
      if (fill.way1We && fill.markValid) begin
        valid1[lookup.set] <= 1'b1;
      end
      if (fill.way2We && fill.markValid) begin
        valid2[lookup.set] <= 1'b1;
      end
      // Way just read becomes most recent
      if (readHit) begin
        lru[lookup.set] <= ~fill.wayRead;
      end
    end
  end

  // Fill writes, one word per data beat
  always_ff @(posedge clk) begin
    if (fill.way1We) begin
      data1[lookup.set][fill.wayOffset] <= busData;
      if (fill.markValid) begin
        tag1[lookup.set] <= lookup.tag;
      end
    end
    if (fill.way2We) begin
      data2[lookup.set][fill.wayOffset] <= busData;
      if (fill.markValid) begin
        tag2[lookup.set] <= lookup.tag;
      end
    end
  end

endmodule

//--- icache/icacheMissController.sv
/* Instruction cache miss controller
   Detects hits, stalls the fetch on a miss and runs the block fill over the
   pipelined bus, address phase one beat ahead of the data phase */

`timescale 1ns/1ps

module icacheMissController (
  input  logic                clk,
  input  logic                reset,
  input  logic                cacheEnable,
  input  icachePkg::lookupT   lookup,
  input  icachePkg::wayTagsT  tags,
  input  logic                busReady,
  output icachePkg::fillT     fill,
  output logic                stall,
  output logic                instrValid,
  output logic                busRequest,
  output icachePkg::wordAddrT busAddr
);

  import icachePkg::*;

  typedef enum logic [1:0] {READY, MEMREAD, LASTREAD, NEXTINSTR} stateT;

  stateT  state;
  stateT  nextState;

  logic   way1Hit;
  logic   way2Hit;
  logic   hit;
  logic   miss;
  logic   addrAccept;
  logic   dataBeat;
  logic   victimWay1;

  offsetT addrCount;
  offsetT dataCount;
  offsetT addrOffset;
  offsetT dataOffset;

  // Tag compare against both ways
  assign way1Hit = tags.way1Valid & (tags.way1Tag == lookup.tag);
  assign way2Hit = tags.way2Valid & (tags.way2Tag == lookup.tag);

  // Disabled fetches never hit
  assign hit  = lookup.valid & cacheEnable & (way1Hit | way2Hit);
  assign miss = lookup.valid & ~hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      // Leave once the first address is taken
      READY: begin
        if (miss && busReady) begin
          nextState = cacheEnable ? MEMREAD : LASTREAD;
        end
      end
      MEMREAD: begin
        if (busReady && (addrCount == offsetT'(3))) begin
          nextState = LASTREAD;
        end
      end
      // Only the last data beat is outstanding
      LASTREAD: begin
        if (busReady) begin
          nextState = NEXTINSTR;
        end
      end
      NEXTINSTR: nextState = READY;
      default:   nextState = READY;
    endcase
  end

  assign stall      = ((state == READY) & miss) | (state == MEMREAD) | (state == LASTREAD);
  // Held request is returned in NEXTINSTR, also for a disabled read
  assign instrValid = ((state == READY) & hit) | ((state == NEXTINSTR) & lookup.valid);
  assign busRequest = ((state == READY) & miss) | (state == MEMREAD);

  assign addrAccept = busRequest & busReady;
  assign dataBeat   = busReady & ((state == MEMREAD) | (state == LASTREAD));

  // Address beats and data beats, data count trails by one
  always_ff @(posedge clk) begin
    if (reset || (state == NEXTINSTR)) begin
      addrCount <= '0;
      dataCount <= '0;
    end else begin
      if (addrAccept) begin
        addrCount <= addrCount + offsetT'(1);
      end
      if (dataBeat) begin
        dataCount <= dataCount + offsetT'(1);
      end
    end
  end

  // Single read at the requested word when disabled
  assign addrOffset = cacheEnable ? addrCount : lookup.offset;
  assign dataOffset = cacheEnable ? dataCount : lookup.offset;

  assign busAddr = {lookup.tag, lookup.set, addrOffset};

  // Victim way. Once the first word lands, the filling way hits and stays chosen
  always_comb begin
    if (!cacheEnable) begin
      victimWay1 = 1'b1;
    end else if (way1Hit) begin
      victimWay1 = 1'b1;
    end else if (way2Hit) begin
      victimWay1 = 1'b0;
    end else if (!tags.way1Valid) begin
      victimWay1 = 1'b1;
    end else if (!tags.way2Valid) begin
      victimWay1 = 1'b0;
    end else begin
      victimWay1 = tags.lru;
    end
  end

  assign fill.way1We    = dataBeat & victimWay1;
  assign fill.way2We    = dataBeat & ~victimWay1;
  assign fill.wayOffset = dataOffset;
  assign fill.markValid = cacheEnable;
  assign fill.wayRead   = ~cacheEnable | way1Hit;

endmodule

//--- hdl/icacheTop.sv
/* Instruction cache top level
   Connects the lookup stage, way store and miss controller to the fetch
   port and the pipelined bus port */

`timescale 1ns/1ps

module icacheTop (
  input  logic                clk,
  input  logic                reset,
  input  logic                cacheEnable,
  input  logic                fetchValid,
  input  icachePkg::wordAddrT fetchAddr,
  input  logic                busReady,
  input  icachePkg::wordT     busData,
  output icachePkg::wordT     instr,
  output logic                instrValid,
  output logic                stall,
  output logic                busRequest,
  output icachePkg::wordAddrT busAddr
);

  import icachePkg::*;

  lookupT  lookup;
  wayTagsT tags;
  fillT    fill;

  icacheLookup icacheLookup_i (
    .clk        (clk),
    .reset      (reset),
    .fetchValid (fetchValid),
    .fetchAddr  (fetchAddr),
    .stall      (stall),
    .lookup     (lookup)
  );

  // Fill data comes straight from the bus
  icacheWays icacheWays_i (
    .clk         (clk),
    .reset       (reset),
    .lookup      (lookup),
    .fill        (fill),
    .busData     (busData),
    .cacheEnable (cacheEnable),
    .tags        (tags),
    .instr       (instr)
  );

  icacheMissController icacheMissController_i (
    .clk         (clk),
    .reset       (reset),
    .cacheEnable (cacheEnable),
    .lookup      (lookup),
    .tags        (tags),
    .busReady    (busReady),
    .fill        (fill),
    .stall       (stall),
    .instrValid  (instrValid),
    .busRequest  (busRequest),
    .busAddr     (busAddr)
  );

endmodule

//--- tb/busMemModel.sv
/* Pipelined bus memory model
   Returns a computed word per address, one data beat after each accepted
   address phase, with optional LCG wait states on busReady */

`timescale 1ns/1ps

module busMemModel (
  input  logic                clk,
  input  logic                reset,
  input  logic                waitStates,
  input  logic                busRequest,
  input  icachePkg::wordAddrT busAddr,
  output logic                busReady,
  output icachePkg::wordT     busData,
  output int                  readCount
);

  import icachePkg::*;

  logic [31:0] lcgState = 32'd33;
  logic        ready = 1'b1;
  logic        waitsQ = 1'b0;
  wordAddrT    pendingAddr = '0;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Address times the golden ratio constant, then a fixed XOR mask
  function automatic wordT memWord(input wordAddrT a);
    logic [31:0] product;
    product = 32'(a) * 32'h9E3779B1;
    return product ^ 32'h5A5A5A5A;
  endfunction

  // Ready changes on the falling edge, like every other cache input
  always @(negedge clk) begin
    if (reset) begin
      lcgState <= 32'd33;
      ready    <= 1'b1;
    end else begin
      lcgState <= lcgNext(lcgState);
      ready    <= waitsQ ? lcgState[16] : 1'b1;
    end
  end

  // Address phase accepted when request and ready meet
  always @(posedge clk) begin
    waitsQ <= waitStates;
    if (reset) begin
      readCount <= 0;
    end else if (busRequest && ready) begin
      pendingAddr <= busAddr;
      readCount   <= readCount + 1;
    end
  end

  assign busReady = ready;
  assign busData  = memWord(pendingAddr);

endmodule

//--- tb/icacheTb.sv
/* Instruction cache testbench
   Applies a table of fetches and checks words, hit or miss and bus reads */

`timescale 1ns/1ps

module icacheTb;

  import icachePkg::*;

  localparam int NumTests    = 24;
  localparam int ResetCycles = 4;
  localparam int CycleLimit  = NumTests * 40 + ResetCycles;

  typedef struct packed {
    wordAddrT   addr;
    logic       enable;
    logic       waits;
    logic       expHit;
    logic [2:0] expReads;
  } testT;

  logic     clk = 1'b0;
  logic     reset;
  logic     cacheEnable;
  logic     fetchValid;
  wordAddrT fetchAddr;
  logic     waitStates;
  wordT     instr;
  logic     instrValid;
  logic     stall;
  logic     busRequest;
  wordAddrT busAddr;
  logic     busReady;
  wordT     busData;
  int       readCount;

  testT     tests [NumTests];
  wordAddrT busLog [$];
  int       cycles = 0;
  int       errors = 0;
  int       failedTests = 0;

  icacheTop icacheTop_i (
    .clk(clk), .reset(reset), .cacheEnable(cacheEnable), .fetchValid(fetchValid),
    .fetchAddr(fetchAddr), .busReady(busReady), .busData(busData), .instr(instr),
    .instrValid(instrValid), .stall(stall), .busRequest(busRequest), .busAddr(busAddr)
  );

  busMemModel busMem (
    .clk(clk), .reset(reset), .waitStates(waitStates), .busRequest(busRequest),
    .busAddr(busAddr), .busReady(busReady), .busData(busData), .readCount(readCount)
  );

  always #2 clk = ~clk;

  // Accepted address phases in order
  always @(posedge clk) begin
    if (!reset && busRequest && busReady) begin
      busLog.push_back(busAddr);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic wordT expectedWord(input wordAddrT a);
    logic [31:0] product;
    product = 32'(a) * 32'h9E3779B1;
    return product ^ 32'h5A5A5A5A;
  endfunction

  // Columns are address, enable, wait states, expected hit, expected bus reads
  task automatic loadTests();
    tests[0]  = '{20'h00046, 1'b1, 1'b0, 1'b0, 3'd4};  // Cold block in set 1
    tests[1]  = '{20'h00044, 1'b1, 1'b0, 1'b1, 3'd0};
    tests[2]  = '{20'h00045, 1'b1, 1'b0, 1'b1, 3'd0};
    tests[3]  = '{20'h00047, 1'b1, 1'b0, 1'b1, 3'd0};
    tests[4]  = '{20'h00415, 1'b1, 1'b0, 1'b0, 3'd4};  // Set 5, three tags
    tests[5]  = '{20'h00816, 1'b1, 1'b0, 1'b0, 3'd4};
    tests[6]  = '{20'h00817, 1'b1, 1'b0, 1'b1, 3'd0};
    tests[7]  = '{20'h00414, 1'b1, 1'b0, 1'b1, 3'd0};
    tests[8]  = '{20'h00C16, 1'b1, 1'b0, 1'b0, 3'd4};  // Evicts 0x816 block
    tests[9]  = '{20'h00415, 1'b1, 1'b0, 1'b1, 3'd0};
    tests[10] = '{20'h00816, 1'b1, 1'b0, 1'b0, 3'd4};
    tests[11] = '{20'h00045, 1'b0, 1'b0, 1'b0, 3'd1};  // Cache disabled
    tests[12] = '{20'h00045, 1'b0, 1'b0, 1'b0, 3'd1};
    tests[13] = '{20'h01566, 1'b0, 1'b0, 1'b0, 3'd1};
    tests[14] = '{20'h01566, 1'b0, 1'b0, 1'b0, 3'd1};
    tests[15] = '{20'h00046, 1'b1, 1'b0, 1'b1, 3'd0};
    tests[16] = '{20'h01566, 1'b1, 1'b0, 1'b0, 3'd4};
    tests[17] = '{20'h02ACD, 1'b1, 1'b1, 1'b0, 3'd4};  // Wait states from here on
    tests[18] = '{20'h02ACF, 1'b1, 1'b1, 1'b1, 3'd0};
    tests[19] = '{20'h07FCE, 1'b1, 1'b1, 1'b0, 3'd4};
    tests[20] = '{20'h0E971, 1'b0, 1'b1, 1'b0, 3'd1};
    tests[21] = '{20'h02ACC, 1'b1, 1'b1, 1'b1, 3'd0};
    tests[22] = '{20'hFFFFF, 1'b1, 1'b1, 1'b0, 3'd4};
    tests[23] = '{20'hFFFFC, 1'b1, 1'b1, 1'b1, 3'd0};
  endtask

  task automatic runTest(input int idx);
    testT     t;
    int       startReads;
    int       startLog;
    int       waitCycles;
    int       testErrors;
    int       i;
    logic     sawStall;
    wordT     word;
    wordAddrT expAddr;
    t = tests[idx];
    testErrors = 0;
    waitCycles = 0;
    sawStall = 1'b0;
    startReads = readCount;
    startLog = busLog.size();
    @(negedge clk);
    cacheEnable = t.enable;
    waitStates = t.waits;
    fetchValid = 1'b1;
    fetchAddr = t.addr;
    // Inputs stay put while the cache stalls
    do begin
      @(negedge clk);
      waitCycles++;
      if (stall) begin
        sawStall = 1'b1;
      end
    end while (!instrValid);
    word = instr;
    fetchValid = 1'b0;
    assert (word == expectedWord(t.addr)) else begin
      $display("Error at %0t: addr %h returned %h, expected %h",
               $time, t.addr, word, expectedWord(t.addr));
      testErrors++;
    end
    assert (sawStall == !t.expHit && (!t.expHit || waitCycles == 1)) else begin
      $display("Error at %0t: addr %h stall %0b after %0d cycles, expected hit %0b",
               $time, t.addr, sawStall, waitCycles, t.expHit);
      testErrors++;
    end
    assert (readCount - startReads == int'(t.expReads)) else begin
      $display("Error at %0t: addr %h made %0d bus reads, expected %0d",
               $time, t.addr, readCount - startReads, t.expReads);
      testErrors++;
    end
    // A fill reads the block from word 0, a disabled fetch reads its own word
    for (i = 0; i < busLog.size() - startLog; i++) begin
      expAddr = (t.expReads == 3'd1) ? t.addr : {t.addr[19:2], 2'(i)};
      assert (busLog[startLog + i] == expAddr) else begin
        $display("Error at %0t: bus read %0d went to %h, expected %h",
                 $time, i, busLog[startLog + i], expAddr);
        testErrors++;
      end
    end
    $display("Test %0d addr %h enable %0b: %s", idx, t.addr, t.enable,
             (testErrors == 0) ? "ok" : "failed");
    errors += testErrors;
    if (testErrors != 0) begin
      failedTests++;
    end
  endtask

  initial begin
    int idx;
    reset = 1'b1;
    cacheEnable = 1'b1;
    fetchValid = 1'b0;
    fetchAddr = '0;
    waitStates = 1'b0;
    loadTests();
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (!busRequest && !stall && !instrValid) else begin
      $display("Error at %0t: busRequest, stall or instrValid high after reset", $time);
      errors++;
      failedTests++;
    end
    $display("Test reset: %s", (errors == 0) ? "ok" : "failed");
    for (idx = 0; idx < NumTests; idx++) begin
      runTest(idx);
    end
    $display("Tests run: %0d, failed tests: %0d, failed checks: %0d",
             NumTests + 1, failedTests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+common
common/icachePkg.sv
icache/icacheLookup.sv
icache/icacheWays.sv
icache/icacheMissController.sv
hdl/icacheTop.sv
tb/busMemModel.sv
tb/icacheTb.sv

//--- Makefile
# Verilator lint and simulation of the instruction cache

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= icacheTb
RTL_TOP    ?= icacheTop
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_TEXT  ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Pass only when the testbench prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
